// ==== dv/cpuTb.sv ====
////////////////////////////////////////
// Testbench for the 16-bit pipeline
// Programs hold up to 16 words, padded with HALT
// Every program must reach HALT
// Inputs change on the falling edge, outputs are
// sampled there too
////////////////////////////////////////
`timescale 1ns/1ps
module cpuTb import cpuPkg::*; ();

	localparam int numTests = 6;
	localparam int progWords = 16;
	localparam int clkPeriod = 100;
	localparam int cyclesPerTest = 200;
	localparam int drainCycles = 5;

	logic clk = 1'b0;
	logic rst;
	progLoad_t progLoad;
	wbBundle_t commit;
	logic halted;
	logic err;

	// Test table
	string testName [numTests];
	word_t progTab [numTests][progWords];
	int progLen [numTests];
	regIdx_t expReg [numTests][progWords];
	word_t expVal [numTests][progWords];
	int expCount [numTests];
	logic expErr [numTests];

	string curTest;
	logic [31:0] lcgState = 32'h4494_3bd4;

	cpuTop dut0 (
		.clk(clk),
		.rst(rst),
		.progLoad(progLoad),
		.commit(commit),
		.halted(halted),
		.err(err)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// Instruction encoders, fields as in the ISA layout
	function automatic word_t rType(opcode_e op, regIdx_t rd, regIdx_t rs, regIdx_t rt);
		return {op, rd, rs, rt, 3'b000};
	endfunction

	function automatic word_t iType(opcode_e op, regIdx_t rd, regIdx_t rs, logic [5:0] imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic word_t jumpTo(logic [11:0] offset);
		return {J, offset};
	endfunction

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic pushInstr(int t, word_t instr);
		progTab[t][progLen[t]] = instr;
		progLen[t]++;
	endtask

	task automatic expectCommit(int t, regIdx_t dest, word_t value);
		expReg[t][expCount[t]] = dest;
		expVal[t][expCount[t]] = value;
		expCount[t]++;
	endtask

	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkValue(string what, word_t expected, word_t actual);
		if (expected !== actual) begin
			abortRun($sformatf("ERR %s %s: expected %h, actual %h",
				curTest, what, expected, actual));
		end
	endtask

	task automatic buildTable();
		logic [31:0] rnd;
		logic [5:0] imm;
		word_t sum;
		for (int t = 0; t < numTests; t++) begin
			progLen[t] = 0;
			expCount[t] = 0;
			expErr[t] = 1'b0;
			for (int i = 0; i < progWords; i++) begin
				progTab[t][i] = {HALT, 12'h000};
			end
		end

		testName[0] = "alu";
		pushInstr(0, iType(ADDI, 3'd1, 3'd0, 6'd13));
		pushInstr(0, iType(ADDI, 3'd2, 3'd0, 6'(-20)));
		pushInstr(0, rType(ADD, 3'd3, 3'd1, 3'd2));
		pushInstr(0, rType(SUB, 3'd4, 3'd1, 3'd2));
		pushInstr(0, rType(AND, 3'd5, 3'd3, 3'd2));
		pushInstr(0, rType(XOR, 3'd6, 3'd5, 3'd1));
		pushInstr(0, rType(SUB, 3'd7, 3'd0, 3'd6));
		pushInstr(0, rType(ADD, 3'd1, 3'd7, 3'd7));
		expectCommit(0, 3'd1, 16'h000D);
		expectCommit(0, 3'd2, 16'hFFEC);
		// 13 - 20 wraps
		expectCommit(0, 3'd3, 16'hFFF9);
		expectCommit(0, 3'd4, 16'h0021);
		expectCommit(0, 3'd5, 16'hFFE8);
		expectCommit(0, 3'd6, 16'hFFE5);
		expectCommit(0, 3'd7, 16'h001B);
		expectCommit(0, 3'd1, 16'h0036);

		testName[1] = "memory";
		pushInstr(1, iType(ADDI, 3'd1, 3'd0, 6'd25));
		pushInstr(1, iType(ADDI, 3'd2, 3'd0, 6'd6));
		// Store r1 at r2 + 4, then load it back
		pushInstr(1, iType(ST, 3'd1, 3'd2, 6'd4));
		pushInstr(1, iType(LD, 3'd3, 3'd2, 6'd4));
		pushInstr(1, iType(ADDI, 3'd0, 3'd0, 6'd5));
		pushInstr(1, iType(ADDI, 3'd4, 3'd0, 6'd7));
		pushInstr(1, rType(ADD, 3'd5, 3'd3, 3'd0));
		// Stalls on r5, so r0 is read after its write has retired
		pushInstr(1, rType(ADD, 3'd6, 3'd0, 3'd5));
		expectCommit(1, 3'd1, 16'd25);
		expectCommit(1, 3'd2, 16'd6);
		expectCommit(1, 3'd3, 16'd25);
		expectCommit(1, 3'd0, 16'd5);
		expectCommit(1, 3'd4, 16'd7);
		expectCommit(1, 3'd5, 16'd25);
		expectCommit(1, 3'd6, 16'd25);

		testName[2] = "branch";
		pushInstr(2, iType(ADDI, 3'd1, 3'd0, 6'd3));
		pushInstr(2, iType(BEQZ, 3'd0, 3'd0, 6'd1));
		pushInstr(2, iType(ADDI, 3'd2, 3'd0, 6'd9));
		pushInstr(2, iType(BEQZ, 3'd0, 3'd1, 6'd1));
		pushInstr(2, iType(ADDI, 3'd3, 3'd0, 6'd11));
		expectCommit(2, 3'd1, 16'd3);
		expectCommit(2, 3'd3, 16'd11);

		testName[3] = "jumpHalt";
		pushInstr(3, iType(ADDI, 3'd1, 3'd0, 6'd1));
		pushInstr(3, jumpTo(12'd2));
		pushInstr(3, iType(ADDI, 3'd2, 3'd0, 6'd2));
		pushInstr(3, iType(ADDI, 3'd3, 3'd0, 6'd3));
		pushInstr(3, iType(ADDI, 3'd4, 3'd0, 6'd4));
		pushInstr(3, {HALT, 12'h000});
		pushInstr(3, iType(ADDI, 3'd5, 3'd0, 6'd5));
		pushInstr(3, iType(ADDI, 3'd6, 3'd0, 6'd6));
		expectCommit(3, 3'd1, 16'd1);
		expectCommit(3, 3'd4, 16'd4);

		testName[4] = "addiChain";
		sum = '0;
		for (int k = 0; k < 10; k++) begin
			rnd = nextRandom();
			imm = rnd[21:16];
			pushInstr(4, iType(ADDI, 3'd1, 3'd1, imm));
			sum = sum + {{10{imm[5]}}, imm};
			expectCommit(4, 3'd1, sum);
		end

		testName[5] = "illegal";
		pushInstr(5, iType(ADDI, 3'd1, 3'd0, 6'd2));
		pushInstr(5, 16'hF000);
		pushInstr(5, iType(ADDI, 3'd2, 3'd1, 6'd1));
		expectCommit(5, 3'd1, 16'd2);
		expectCommit(5, 3'd2, 16'd3);
		expErr[5] = 1'b1;
	endtask

	task automatic loadProgram(int t);
		@(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < progWords; i++) begin
			progLoad.valid = 1'b1;
			progLoad.addr = memIdx_t'(i);
			progLoad.data = progTab[t][i];
			@(negedge clk);
		end
		progLoad = '0;
		rst = 1'b0;
	endtask

	task automatic runTest(int t);
		int nCommit;
		nCommit = 0;
		curTest = testName[t];
		loadProgram(t);
		checkValue("err after reset", 16'd0, word_t'(err));
		checkValue("halted after reset", 16'd0, word_t'(halted));
		while (!halted) begin
			@(negedge clk);
			if (commit.valid) begin
				if (nCommit >= expCount[t]) begin
					abortRun($sformatf("%s: more commits than the program should produce",
						curTest));
				end else begin
					checkValue("commit regWrite", 16'd1, word_t'(commit.regWrite));
					checkValue("commit dest", word_t'(expReg[t][nCommit]),
						word_t'(commit.dest));
					checkValue("commit data", expVal[t][nCommit], commit.data);
					nCommit++;
				end
			end
		end
		// Nothing younger than HALT may commit
		repeat (drainCycles) begin
			@(negedge clk);
			checkValue("commit after halt", 16'd0, word_t'(commit.valid));
		end
		checkValue("commit count", word_t'(expCount[t]), word_t'(nCommit));
		checkValue("err", word_t'(expErr[t]), word_t'(err));
	endtask

	// Watchdog
	initial begin
		#(numTests * cyclesPerTest * clkPeriod);
		abortRun("Timeout: the tests did not finish in the allowed time");
	end

	initial begin
		rst = 1'b1;
		progLoad = '0;
		curTest = "reset";
		buildTable();
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int t = 0; t < numTests; t++) begin
			runTest(t);
		end
		// err from the illegal test clears only on a new reset
		curTest = "finalReset";
		@(negedge clk);
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		checkValue("err after reset", 16'd0, word_t'(err));
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== files.f ====
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/hazardControl.sv
logic/cpuTop.sv
dv/cpuTb.sv

// ==== logic/cpuPkg.sv ====
////////////////////////////////////////
// Shared types for the 16-bit pipeline
// Opcodes 10 to 15 are illegal and raise err
// PC is a byte address and steps by 2
// Instruction and data memories hold 256 words each
////////////////////////////////////////
package cpuPkg;

	localparam int dataWidth = 16;
	localparam int regCount = 8;
	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;

	typedef logic [dataWidth-1:0] word_t;
	typedef logic [dataWidth-1:0] pc_t;
	typedef logic [$clog2(regCount)-1:0] regIdx_t;
	typedef logic [$clog2(imemDepth)-1:0] memIdx_t;

	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		AND  = 4'd2,
		XOR  = 4'd3,
		ADDI = 4'd4,
		LD   = 4'd5,
		ST   = 4'd6,
		BEQZ = 4'd7,
		J    = 4'd8,
		HALT = 4'd9
	} opcode_e;

	typedef enum logic [1:0] {
		LOADING,
		RUNNING,
		STOPPED
	} fetchState_e;

	typedef struct packed {
		logic    valid;
		memIdx_t addr;
		word_t   data;
	} progLoad_t;

	typedef struct packed {
		logic  valid;
		word_t instr;
		pc_t   pcNext;
	} ifId_t;

	typedef struct packed {
		logic    valid;
		opcode_e opcode;
		regIdx_t dest;
		logic    regWrite;
		word_t   opA;
		word_t   opB;
		word_t   imm;
		word_t   storeData;
		logic    halt;
	} idEx_t;

	typedef struct packed {
		logic    valid;
		opcode_e opcode;
		regIdx_t dest;
		logic    regWrite;
		word_t   result;
		word_t   storeData;
		logic    halt;
	} exMem_t;

	typedef struct packed {
		logic    valid;
		logic    regWrite;
		regIdx_t dest;
		word_t   data;
	} wbBundle_t;

	// Field extraction, shared by decode and hazard control
	function automatic opcode_e instrOpcode(word_t instr);
		return opcode_e'(instr[15:12]);
	endfunction

	function automatic regIdx_t instrRd(word_t instr);
		return instr[11:9];
	endfunction

	function automatic regIdx_t instrRs(word_t instr);
		return instr[8:6];
	endfunction

	function automatic regIdx_t instrRt(word_t instr);
		return instr[5:3];
	endfunction

	function automatic word_t instrImm6(word_t instr);
		return {{10{instr[5]}}, instr[5:0]};
	endfunction

	function automatic word_t instrImm12(word_t instr);
		return {{4{instr[11]}}, instr[11:0]};
	endfunction

endpackage

// ==== logic/cpuTop.sv ====
////////////////////////////////////////
// Five-stage 16-bit pipeline, top level
// Load the program while rst is high
// commit reports each register write in order
////////////////////////////////////////
`timescale 1ns/1ps
module cpuTop import cpuPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  progLoad_t progLoad,
	output wbBundle_t commit,
	output logic      halted,
	output logic      err
);
	ifId_t ifId;
	idEx_t idEx;
	exMem_t exMem;
	logic stall;
	logic redirectTaken;
	pc_t redirectTarget;

	fetchStage fetch0 (
		.clk(clk),
		.rst(rst),
		.progLoad(progLoad),
		.stall(stall),
		.redirectTaken(redirectTaken),
		.redirectTarget(redirectTarget),
		.halted(halted),
		.ifId(ifId)
	);

	decodeStage decode0 (
		.clk(clk),
		.rst(rst),
		.ifId(ifId),
		.stall(stall),
		.wb(commit),
		.idEx(idEx),
		.redirectTaken(redirectTaken),
		.redirectTarget(redirectTarget),
		.err(err)
	);

	hazardControl hazard0 (
		.ifId(ifId),
		.exRegDest(idEx.dest),
		.exRegWrite(idEx.regWrite),
		.memRegDest(exMem.dest),
		.memRegWrite(exMem.regWrite),
		.stall(stall)
	);

	executeStage execute0 (
		.clk(clk),
		.rst(rst),
		.idEx(idEx),
		.exMem(exMem)
	);

	memoryStage memory0 (
		.clk(clk),
		.rst(rst),
		.exMem(exMem),
		.wb(commit),
		.halted(halted)
	);

endmodule

// ==== logic/decodeStage.sv ====
////////////////////////////////////////
// Decode, register file and branch resolution
// Register writes bypass to same-cycle reads
// r0 is never written and reads zero
// Instructions behind a HALT are squashed here
////////////////////////////////////////
`timescale 1ns/1ps
module decodeStage import cpuPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  ifId_t     ifId,
	input  logic      stall,
	input  wbBundle_t wb,
	output idEx_t     idEx,
	output logic      redirectTaken,
	output pc_t       redirectTarget,
	output logic      err
);
	word_t regFile [regCount];
	opcode_e opc;
	regIdx_t rd;
	regIdx_t rs;
	regIdx_t rt;
	word_t rsVal;
	word_t rtVal;
	word_t rdVal;
	word_t imm6Ext;
	word_t imm12Ext;
	logic haltSeen;
	logic live;
	logic legal;
	logic writesReg;
	logic isBranch;
	logic issue;

	function automatic word_t readReg(regIdx_t idx);
		word_t val;
		if (idx != '0 && wb.valid && wb.regWrite && wb.dest == idx) begin
			val = wb.data;
		end else begin
			val = regFile[idx];
		end
		return val;
	endfunction

	assign opc = instrOpcode(ifId.instr);
	assign rd = instrRd(ifId.instr);
	assign rs = instrRs(ifId.instr);
	assign rt = instrRt(ifId.instr);
	assign imm6Ext = instrImm6(ifId.instr);
	assign imm12Ext = instrImm12(ifId.instr);

	always_comb begin
		rsVal = readReg(rs);
		rtVal = readReg(rt);
		rdVal = readReg(rd);
	end

	always_comb begin
		legal = 1'b1;
		writesReg = 1'b0;
		case (opc)
			ADD, SUB, AND, XOR, ADDI, LD: writesReg = 1'b1;
			ST, BEQZ, J, HALT: writesReg = 1'b0;
			default: legal = 1'b0;
		endcase
	end

	assign live = ifId.valid && !haltSeen;
	assign isBranch = (opc == BEQZ) || (opc == J);
	assign issue = live && !stall && legal && !isBranch;

	// Branch operand is only trusted once the stall has cleared
	assign redirectTaken = live && !stall && ((opc == BEQZ && rsVal == '0) || opc == J);
	assign redirectTarget = ifId.pcNext + ((opc == J) ? (imm12Ext << 1) : (imm6Ext << 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
		end else if (wb.valid && wb.regWrite && wb.dest != '0) begin
			regFile[wb.dest] <= wb.data;
		end
	end

	always_ff @(posedge clk) begin
		idEx.opcode <= opc;
		idEx.dest <= rd;
		idEx.opA <= rsVal;
		idEx.opB <= rtVal;
		idEx.imm <= imm6Ext;
		idEx.storeData <= rdVal;
		if (rst) begin
			idEx.valid <= 1'b0;
			idEx.regWrite <= 1'b0;
			idEx.halt <= 1'b0;
		end else begin
			idEx.valid <= issue;
			idEx.regWrite <= issue && writesReg;
			idEx.halt <= issue && (opc == HALT);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			haltSeen <= 1'b0;
			err <= 1'b0;
		end else begin
			if (live && !stall && opc == HALT) haltSeen <= 1'b1;
			if (live && !legal) err <= 1'b1;
		end
	end

endmodule

// ==== logic/executeStage.sv ====
////////////////////////////////////////
// ALU and address adder
// All arithmetic wraps at 16 bits
////////////////////////////////////////
`timescale 1ns/1ps
module executeStage import cpuPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  idEx_t  idEx,
	output exMem_t exMem
);
	word_t result;

	always_comb begin
		case (idEx.opcode)
			ADD: result = idEx.opA + idEx.opB;
			SUB: result = idEx.opA - idEx.opB;
			AND: result = idEx.opA & idEx.opB;
			XOR: result = idEx.opA ^ idEx.opB;
			// ADDI and the LD/ST effective address
			default: result = idEx.opA + idEx.imm;
		endcase
	end

	always_ff @(posedge clk) begin
		exMem.opcode <= idEx.opcode;
		exMem.dest <= idEx.dest;
		exMem.result <= result;
		exMem.storeData <= idEx.storeData;
		if (rst) begin
			exMem.valid <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.halt <= 1'b0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.regWrite <= idEx.regWrite;
			exMem.halt <= idEx.halt;
		end
	end

endmodule

// ==== logic/fetchStage.sv ====
////////////////////////////////////////
// Fetch with instruction memory and PC
// progLoad writes memory only while rst is high
// Fetch starts one cycle after rst drops
////////////////////////////////////////
`timescale 1ns/1ps
module fetchStage import cpuPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  progLoad_t progLoad,
	input  logic      stall,
	input  logic      redirectTaken,
	input  pc_t       redirectTarget,
	input  logic      halted,
	output ifId_t     ifId
);
	word_t imem [imemDepth];
	fetchState_e state;
	pc_t pc;
	pc_t pcPlusTwo;
	logic fetching;

	assign pcPlusTwo = pc + pc_t'(2);
	assign fetching = (state == RUNNING) && !halted;

	always_ff @(posedge clk) begin
		if (rst && progLoad.valid) begin
			imem[progLoad.addr] <= progLoad.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LOADING;
		end else begin
			case (state)
				LOADING: state <= RUNNING;
				RUNNING: if (halted) state <= STOPPED;
				STOPPED: state <= STOPPED;
				default: state <= STOPPED;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (fetching) begin
			if (redirectTaken) begin
				pc <= redirectTarget;
			end else if (!stall) begin
				pc <= pcPlusTwo;
			end
		end
	end

	// Taken branch in decode kills the instruction fetched behind it
	always_ff @(posedge clk) begin
		if (!stall) begin
			ifId.instr <= imem[pc[8:1]];
			ifId.pcNext <= pcPlusTwo;
		end
		if (rst || redirectTaken) begin
			ifId.valid <= 1'b0;
		end else if (!stall) begin
			ifId.valid <= fetching;
		end
	end

	pcEven: assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0)
		else $error("PC became odd");

endmodule

// ==== logic/hazardControl.sv ====
////////////////////////////////////////
// Stall on register dependences
// No forwarding; write-back is covered by
// the register file bypass
////////////////////////////////////////
`timescale 1ns/1ps
module hazardControl import cpuPkg::*; (
	input  ifId_t   ifId,
	input  regIdx_t exRegDest,
	input  logic    exRegWrite,
	input  regIdx_t memRegDest,
	input  logic    memRegWrite,
	output logic    stall
);
	opcode_e opc;
	logic readsRs;
	logic readsRt;
	logic readsRd;
	logic rsBusy;
	logic rtBusy;
	logic rdBusy;

	function automatic logic isPending(regIdx_t src, regIdx_t dest, logic wr);
		return wr && (dest == src) && (src != '0);
	endfunction

	assign opc = instrOpcode(ifId.instr);

	always_comb begin
		readsRs = 1'b0;
		readsRt = 1'b0;
		readsRd = 1'b0;
		case (opc)
			ADD, SUB, AND, XOR: begin
				readsRs = 1'b1;
				readsRt = 1'b1;
			end
			ADDI, LD, BEQZ: readsRs = 1'b1;
			// Store data comes from rd
			ST: begin
				readsRs = 1'b1;
				readsRd = 1'b1;
			end
			default: ;
		endcase
	end

	assign rsBusy = isPending(instrRs(ifId.instr), exRegDest, exRegWrite)
		|| isPending(instrRs(ifId.instr), memRegDest, memRegWrite);
	assign rtBusy = isPending(instrRt(ifId.instr), exRegDest, exRegWrite)
		|| isPending(instrRt(ifId.instr), memRegDest, memRegWrite);
	assign rdBusy = isPending(instrRd(ifId.instr), exRegDest, exRegWrite)
		|| isPending(instrRd(ifId.instr), memRegDest, memRegWrite);

	assign stall = ifId.valid
		&& ((readsRs && rsBusy) || (readsRt && rtBusy) || (readsRd && rdBusy));

endmodule

// ==== logic/memoryStage.sv ====
////////////////////////////////////////
// Data memory and write-back register
// Word access only, address bits 8..1
// halted is sticky until reset
////////////////////////////////////////
`timescale 1ns/1ps
module memoryStage import cpuPkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  exMem_t    exMem,
	output wbBundle_t wb,
	output logic      halted
);
	word_t dmem [dmemDepth];
	memIdx_t dmemIdx;
	logic storeEn;
	word_t wbData;

	assign dmemIdx = exMem.result[8:1];
	assign storeEn = exMem.valid && (exMem.opcode == ST) && !halted;
	assign wbData = (exMem.opcode == LD) ? dmem[dmemIdx] : exMem.result;

	always_ff @(posedge clk) begin
		if (storeEn) begin
			dmem[dmemIdx] <= exMem.storeData;
		end
	end

	// Only register writes are reported, so valid follows regWrite
	always_ff @(posedge clk) begin
		wb.dest <= exMem.dest;
		wb.data <= wbData;
		if (rst) begin
			wb.valid <= 1'b0;
			wb.regWrite <= 1'b0;
			halted <= 1'b0;
		end else begin
			wb.valid <= exMem.valid && exMem.regWrite && !halted;
			wb.regWrite <= exMem.regWrite && !halted;
			halted <= halted || (exMem.valid && exMem.halt);
		end
	end

	stNoCommit: assert property (@(posedge clk) disable iff (rst)
		(exMem.valid && exMem.opcode == ST) |=> !wb.valid)
		else $error("store produced a commit");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the cpuTb simulation with Verilator, runs it and checks the log
set -u -o pipefail

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=simCpu
logFile=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module cpuTb --Mdir "$buildDir" -o "$simName"; then
	echo "Verilator build failed"
	exit 1
fi

if ! "./$buildDir/$simName" 2>&1 | tee "$logFile"; then
	echo "Simulation exited with an error status"
	exit 1
fi

if grep -qx "TB PASSED" "$logFile"; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi
